/* Makefile */
VERILATOR ?= verilator
TOP       := tb_proto_handler
FILELIST  := compile.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert
SIM_FLAGS := --binary -j 0 --Mdir $(OBJ_DIR)
SIM_EXE   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# static checks only, no build
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, exit status follows the testbench
sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_EXE)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+design
design/ph_pkg.sv
design/frame_store.sv
design/header_parser.sv
design/reply_composer.sv
design/proto_handler.sv
tests/ph_assertions.sv
tests/tb_proto_handler.sv

/* design/frame_store.sv */
`timescale 1ns/1ps
`include "ph_macros.svh"

module frame_store (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_rx_valid,
  input  ph_pkg::byte_t      i_rx_data,
  input  logic               i_rx_last,
  output logic               o_rx_ready,
  output logic               o_byte_stb,
  output ph_pkg::byte_t      o_byte,
  output ph_pkg::frame_len_t o_byte_pos,
  output logic               o_frame_held,
  output ph_pkg::frame_len_t o_frame_len,
  input  ph_pkg::buf_addr_t  i_rd_addr,
  output ph_pkg::byte_t      o_rd_data,
  input  logic               i_release
);

  ph_pkg::store_state_e state;
  ph_pkg::frame_len_t   count;
  ph_pkg::byte_t        mem [`PH_BUF_DEPTH];
  logic                 take;

  assign o_rx_ready   = (state == ph_pkg::RECEIVE);
  assign take         = i_rx_valid && o_rx_ready;
  assign o_frame_held = (state == ph_pkg::HOLD);
  assign o_frame_len  = count;

  // every accepted byte goes to the parser with its position
  assign o_byte_stb = take;
  assign o_byte     = i_rx_data;
  assign o_byte_pos = count;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ph_pkg::RECEIVE;
      count <= '0;
    end else begin
      case (state)
        ph_pkg::RECEIVE: begin
          // saturate at full buffer, extra bytes dropped
          if (take && count != `PH_BUF_DEPTH)
            count <= count + 7'd1;
          if (take && i_rx_last)
            state <= ph_pkg::HOLD;
        end
        default: begin
          if (i_release) begin
            state <= ph_pkg::RECEIVE;
            count <= '0;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // frame buffer, registered read port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (take && count != `PH_BUF_DEPTH)
      mem[count[5:0]] <= i_rx_data;
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* design/header_parser.sv */
`timescale 1ns/1ps
`include "ph_macros.svh"

module header_parser (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_byte_stb,
  input  ph_pkg::byte_t      i_byte,
  input  ph_pkg::frame_len_t i_byte_pos,
  output ph_pkg::node_addr_t o_src,
  output ph_pkg::node_addr_t o_dst,
  output ph_pkg::pkt_type_t  o_type
);

  logic in_header;

  // payload bytes pass by untouched
  assign in_header = i_byte_stb && (i_byte_pos < `PH_HDR_LEN);

  ////////////////////////////////////////////////////////////
  // header layout: src(2) dst(2) size(2) type(1)
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_src  <= '0;
      o_dst  <= '0;
      o_type <= '0;
    end else if (in_header) begin
      case (i_byte_pos[2:0])
        3'd0: o_src[15:8] <= i_byte;
        3'd1: o_src[7:0]  <= i_byte;
        3'd2: o_dst[15:8] <= i_byte;
        3'd3: o_dst[7:0]  <= i_byte;
        // size bytes 4 and 5 not kept, stored count is used
        3'd6: o_type      <= i_byte;
        default: begin
          o_type <= o_type;
        end
      endcase
    end
  end

endmodule

/* design/ph_macros.svh */
`ifndef PH_MACROS_SVH
`define PH_MACROS_SVH

// sizes, kept at the width of a frame length
`define PH_BUF_DEPTH        7'd64
`define PH_HDR_LEN          7'd7

// type codes
`define PH_TYPE_PING        8'h01
`define PH_TYPE_PING_REPLY  8'h81
`define PH_TYPE_ADDR_REQ    8'h03
`define PH_TYPE_ADDR_GRANT  8'h92
`define PH_ACK_BIT          4

// address handed out in a grant
`define PH_GRANT_ADDR       16'h0120

`endif

/* design/ph_pkg.sv */
package ph_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] node_addr_t;
  typedef logic [5:0]  buf_addr_t;
  // 0 to 64 stored bytes
  typedef logic [6:0]  frame_len_t;
  typedef logic [7:0]  pkt_type_t;
  typedef logic [15:0] scs_t;

  // receive side
  typedef enum logic {RECEIVE, HOLD} store_state_e;

  // transmit side
  typedef enum logic [2:0] {
    IDLE, DECIDE, HEADER, PAYLOAD, CHECKSUM, RELEASE
  } reply_state_e;

endpackage

/* design/proto_handler.sv */
`timescale 1ns/1ps

module proto_handler (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_rx_valid,
  input  ph_pkg::byte_t i_rx_data,
  input  logic          i_rx_last,
  output logic          o_rx_ready,
  output logic          o_tx_valid,
  output ph_pkg::byte_t o_tx_data,
  output logic          o_tx_last,
  input  logic          i_tx_ready
);

  // byte strobe toward the parser
  logic               byte_stb;
  ph_pkg::byte_t      byte_val;
  ph_pkg::frame_len_t byte_pos;

  // held frame and buffer read port
  logic               frame_held;
  ph_pkg::frame_len_t frame_len;
  ph_pkg::buf_addr_t  rd_addr;
  ph_pkg::byte_t      rd_data;
  logic               release_frame;

  // parsed header
  ph_pkg::node_addr_t src;
  ph_pkg::node_addr_t dst;
  ph_pkg::pkt_type_t  pkt_type;

  frame_store u_store (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
    .o_rx_ready(o_rx_ready),
    .o_byte_stb(byte_stb), .o_byte(byte_val), .o_byte_pos(byte_pos),
    .o_frame_held(frame_held), .o_frame_len(frame_len),
    .i_rd_addr(rd_addr), .o_rd_data(rd_data), .i_release(release_frame)
  );

  header_parser u_parser (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_byte_stb(byte_stb), .i_byte(byte_val), .i_byte_pos(byte_pos),
    .o_src(src), .o_dst(dst), .o_type(pkt_type)
  );

  reply_composer u_composer (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_frame_held(frame_held), .i_frame_len(frame_len),
    .i_src(src), .i_dst(dst), .i_type(pkt_type),
    .o_rd_addr(rd_addr), .i_rd_data(rd_data), .o_release(release_frame),
    .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_last(o_tx_last),
    .i_tx_ready(i_tx_ready)
  );

endmodule

/* design/reply_composer.sv */
`timescale 1ns/1ps
`include "ph_macros.svh"

module reply_composer (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_frame_held,
  input  ph_pkg::frame_len_t i_frame_len,
  input  ph_pkg::node_addr_t i_src,
  input  ph_pkg::node_addr_t i_dst,
  input  ph_pkg::pkt_type_t  i_type,
  output ph_pkg::buf_addr_t  o_rd_addr,
  input  ph_pkg::byte_t      i_rd_data,
  output logic               o_release,
  output logic               o_tx_valid,
  output ph_pkg::byte_t      o_tx_data,
  output logic               o_tx_last,
  input  logic               i_tx_ready
);

  ph_pkg::reply_state_e state;
  ph_pkg::frame_len_t   idx;
  ph_pkg::frame_len_t   plen;
  ph_pkg::pkt_type_t    rtype;
  ph_pkg::scs_t         scs;
  ph_pkg::byte_t        next_byte;
  ph_pkg::frame_len_t   rd_next;
  logic                 emitting;
  logic                 load;
  logic                 chk_hi;

  assign emitting   = state inside {ph_pkg::HEADER, ph_pkg::PAYLOAD, ph_pkg::CHECKSUM};

  // output register takes a new byte whenever it is empty or drained
  assign load   = emitting && !o_tx_last && (!o_tx_valid || i_tx_ready);
  assign chk_hi = (idx == plen + `PH_HDR_LEN);

  // ping payload sits at the same index in the buffer
  // read one byte ahead on every load
  assign rd_next   = idx + {6'd0, load};
  assign o_rd_addr = rd_next[5:0];

  assign o_release = (state == ph_pkg::RELEASE);

  ////////////////////////////////////////////////////////////
  // next reply byte
  ////////////////////////////////////////////////////////////
  always_comb begin
    next_byte = 8'h00;
    case (state)
      ph_pkg::HEADER: begin
        case (idx[2:0])
          3'd0: next_byte = i_dst[15:8];
          3'd1: next_byte = i_dst[7:0];
          3'd2: next_byte = i_src[15:8];
          3'd3: next_byte = i_src[7:0];
          // P never exceeds 57
          3'd4: next_byte = 8'h00;
          3'd5: next_byte = {1'b0, plen};
          default: next_byte = rtype;
        endcase
      end
      ph_pkg::PAYLOAD: begin
        if (rtype == `PH_TYPE_ADDR_GRANT)
          next_byte = (idx == `PH_HDR_LEN) ? 8'(`PH_GRANT_ADDR >> 8) : 8'(`PH_GRANT_ADDR);
        else
          next_byte = i_rd_data;
      end
      ph_pkg::CHECKSUM: begin
        next_byte = chk_hi ? scs[15:8] : scs[7:0];
      end
      default: begin
        next_byte = 8'h00;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // reply FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= ph_pkg::IDLE;
      idx        <= '0;
      scs        <= '0;
      o_tx_valid <= 1'b0;
      o_tx_last  <= 1'b0;
    end else begin
      if (load) begin
        o_tx_valid <= 1'b1;
        o_tx_last  <= (state == ph_pkg::CHECKSUM) && !chk_hi;
        idx        <= idx + 7'd1;
        // sum bytes as they enter the output register
        if (state != ph_pkg::CHECKSUM)
          scs <= scs + {8'h00, next_byte};
      end else if (i_tx_ready) begin
        o_tx_valid <= 1'b0;
      end

      case (state)
        ph_pkg::IDLE: begin
          if (i_frame_held)
            state <= ph_pkg::DECIDE;
        end
        ph_pkg::DECIDE: begin
          idx <= '0;
          scs <= '0;
          if (i_frame_len < `PH_HDR_LEN || i_type[`PH_ACK_BIT]) begin
            state <= ph_pkg::RELEASE;
          end else if (i_type == `PH_TYPE_PING) begin
            rtype <= `PH_TYPE_PING_REPLY;
            plen  <= i_frame_len - `PH_HDR_LEN;
            state <= ph_pkg::HEADER;
          end else if (i_type == `PH_TYPE_ADDR_REQ) begin
            rtype <= `PH_TYPE_ADDR_GRANT;
            plen  <= 7'd2;
            state <= ph_pkg::HEADER;
          end else begin
            state <= ph_pkg::RELEASE;
          end
        end
        ph_pkg::HEADER: begin
          if (load && idx == `PH_HDR_LEN - 7'd1)
            state <= (plen == '0) ? ph_pkg::CHECKSUM : ph_pkg::PAYLOAD;
        end
        ph_pkg::PAYLOAD: begin
          if (load && idx == plen + `PH_HDR_LEN - 7'd1)
            state <= ph_pkg::CHECKSUM;
        end
        ph_pkg::CHECKSUM: begin
          // wait for the low checksum byte to leave
          if (o_tx_valid && o_tx_last && i_tx_ready) begin
            o_tx_last <= 1'b0;
            state     <= ph_pkg::RELEASE;
          end
        end
        default: begin
          state <= ph_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (load)
      o_tx_data <= next_byte;
  end

endmodule

/* tests/ph_assertions.sv */
`timescale 1ns/1ps

module ph_assertions (
  input logic          i_clk,
  input logic          i_rst,
  input logic          i_rx_ready,
  input logic          i_tx_valid,
  input ph_pkg::byte_t i_tx_data,
  input logic          i_tx_last,
  input logic          i_tx_ready
);

  // a stalled reply byte must stay put
  a_tx_stable : assert property (@(posedge i_clk) disable iff (i_rst)
    i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_data) && $stable(i_tx_last))
    else $error("reply byte changed while the sink stalled");

  // input side closed while a reply goes out
  a_rx_closed : assert property (@(posedge i_clk) disable iff (i_rst)
    i_tx_valid |-> !i_rx_ready)
    else $error("input ready while a reply byte is valid");

  // nothing valid right after reset
  a_tx_reset : assert property (@(posedge i_clk) i_rst |=> !i_tx_valid)
    else $error("reply valid in the cycle after reset");

endmodule

bind proto_handler ph_assertions u_assertions (
  .i_clk(i_clk), .i_rst(i_rst),
  .i_rx_ready(o_rx_ready),
  .i_tx_valid(o_tx_valid), .i_tx_data(o_tx_data), .i_tx_last(o_tx_last),
  .i_tx_ready(i_tx_ready)
);

/* tests/tb_proto_handler.sv */
`timescale 1ns/1ps
`include "ph_macros.svh"

module tb_proto_handler;

  localparam int NUM_FRAMES = 60;
  localparam int BUF_DEPTH  = 64;
  localparam int HDR_LEN    = 7;

  logic          i_clk;
  logic          i_rst;
  logic          i_rx_valid;
  ph_pkg::byte_t i_rx_data;
  logic          i_rx_last;
  logic          o_rx_ready;
  logic          o_tx_valid;
  ph_pkg::byte_t o_tx_data;
  logic          o_tx_last;
  logic          i_tx_ready;

  int            seed = 32'hae38;
  ph_pkg::byte_t frame_q[$];
  // expected reply bytes with the last flag in bit 8
  logic [8:0]    exp_q[$];

  proto_handler i_dut (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
    .o_rx_ready(o_rx_ready),
    .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_last(o_tx_last),
    .i_tx_ready(i_tx_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("ERROR t=%0t %s got %0h expected %0h",
                         $time, name, actual, expected));
  endtask

  ////////////////////////////////////////////////////////////
  // frame generation
  ////////////////////////////////////////////////////////////
  // 0 ping, 1 long ping, 2 address request, 3 ack, 4 unknown, 5 short
  function automatic int pick_kind();
    int r;
    r = rand_range(0, 9);
    if (r < 4)
      return 0;
    else if (r == 4)
      return 1;
    else if (r < 7)
      return 2;
    else
      return r - 4;
  endfunction

  task automatic make_frame(input int kind);
    int                 len;
    int                 r;
    ph_pkg::node_addr_t src;
    ph_pkg::node_addr_t dst;
    ph_pkg::byte_t      typ;
    r   = rand_range(0, 65535);
    src = r[15:0];
    r   = rand_range(0, 65535);
    dst = r[15:0];
    r   = rand_range(0, 255);
    typ = r[7:0];
    len = rand_range(7, 20);
    case (kind)
      0: begin
        typ = `PH_TYPE_PING;
        len = rand_range(7, 64);
      end
      1: begin
        typ = `PH_TYPE_PING;
        len = rand_range(65, 72);
      end
      2: begin
        typ = `PH_TYPE_ADDR_REQ;
      end
      3: begin
        typ[`PH_ACK_BIT] = 1'b1;
      end
      4: begin
        typ[`PH_ACK_BIT] = 1'b0;
        if (typ == `PH_TYPE_PING || typ == `PH_TYPE_ADDR_REQ)
          typ = 8'h05;
      end
      default: begin
        typ = (rand_range(0, 1) == 0) ? `PH_TYPE_PING : `PH_TYPE_ADDR_REQ;
        len = rand_range(1, 6);
      end
    endcase
    r = len - HDR_LEN;
    frame_q.delete();
    frame_q.push_back(src[15:8]);
    frame_q.push_back(src[7:0]);
    frame_q.push_back(dst[15:8]);
    frame_q.push_back(dst[7:0]);
    frame_q.push_back(r[15:8]);
    frame_q.push_back(r[7:0]);
    frame_q.push_back(typ);
    while (frame_q.size() < len) begin
      r = rand_range(0, 255);
      frame_q.push_back(r[7:0]);
    end
    while (frame_q.size() > len)
      void'(frame_q.pop_back());
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  task automatic model_reply();
    int                 stored;
    int                 plen;
    int                 k;
    logic [15:0]        sum;
    logic [15:0]        grant;
    ph_pkg::node_addr_t src;
    ph_pkg::node_addr_t dst;
    ph_pkg::byte_t      typ;
    ph_pkg::byte_t      rep[$];
    // bytes past the buffer are dropped
    stored = (frame_q.size() > BUF_DEPTH) ? BUF_DEPTH : frame_q.size();
    if (stored < HDR_LEN)
      return;
    src   = {frame_q[0], frame_q[1]};
    dst   = {frame_q[2], frame_q[3]};
    typ   = frame_q[6];
    grant = `PH_GRANT_ADDR;
    if (typ[`PH_ACK_BIT])
      return;
    if (typ == `PH_TYPE_PING)
      plen = stored - HDR_LEN;
    else if (typ == `PH_TYPE_ADDR_REQ)
      plen = 2;
    else
      return;
    // addresses swapped
    rep.push_back(dst[15:8]);
    rep.push_back(dst[7:0]);
    rep.push_back(src[15:8]);
    rep.push_back(src[7:0]);
    rep.push_back(plen[15:8]);
    rep.push_back(plen[7:0]);
    if (typ == `PH_TYPE_PING) begin
      rep.push_back(`PH_TYPE_PING_REPLY);
      for (k = HDR_LEN; k < stored; k++)
        rep.push_back(frame_q[k]);
    end else begin
      rep.push_back(`PH_TYPE_ADDR_GRANT);
      rep.push_back(grant[15:8]);
      rep.push_back(grant[7:0]);
    end
    sum = 16'h0000;
    for (k = 0; k < rep.size(); k++) begin
      sum = sum + {8'h00, rep[k]};
      exp_q.push_back({1'b0, rep[k]});
    end
    exp_q.push_back({1'b0, sum[15:8]});
    exp_q.push_back({1'b1, sum[7:0]});
  endtask

  task automatic send_frame();
    int i;
    int gap;
    for (i = 0; i < frame_q.size(); i++) begin
      if (rand_range(0, 3) == 0) begin
        gap = rand_range(1, 3);
        i_rx_valid <= 1'b0;
        repeat (gap) @(posedge i_clk);
      end
      i_rx_valid <= 1'b1;
      i_rx_data  <= frame_q[i];
      i_rx_last  <= (i == frame_q.size() - 1);
      @(posedge i_clk);
      // hold the byte until it is taken
      while (!o_rx_ready)
        @(posedge i_clk);
    end
    i_rx_valid <= 1'b0;
    i_rx_last  <= 1'b0;
    // input closes once the frame is held
    @(posedge i_clk);
    check_value("o_rx_ready", 32'(o_rx_ready), 32'(1'b0));
  endtask

  // random back-pressure on the reply side
  initial begin
    forever begin
      @(posedge i_clk);
      i_tx_ready <= (rand_range(0, 3) != 0);
    end
  end

  initial begin : tx_monitor
    logic [8:0] want;
    forever begin
      @(posedge i_clk);
      if (o_tx_valid && i_tx_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("reply byte seen while no reply was due");
        end else begin
          want = exp_q.pop_front();
          check_value("o_tx_data", 32'(o_tx_data), 32'(want[7:0]));
          check_value("o_tx_last", 32'(o_tx_last), 32'(want[8]));
        end
      end
    end
  end

  initial begin
    repeat (16 + NUM_FRAMES * 200) @(posedge i_clk);
    fail_run("timeout, the frames did not finish in the allowed cycles");
  end

  initial begin : stimulus
    int f;
    int kind;
    i_rst      = 1'b1;
    i_rx_valid = 1'b0;
    i_rx_data  = '0;
    i_rx_last  = 1'b0;
    i_tx_ready = 1'b0;
    repeat (16) @(posedge i_clk);
    // input side open out of reset
    check_value("o_rx_ready", 32'(o_rx_ready), 32'(1'b1));
    i_rst <= 1'b0;
    for (f = 0; f < NUM_FRAMES; f++) begin
      // each kind once before the random mix
      if (f < 6)
        kind = f;
      else
        kind = pick_kind();
      make_frame(kind);
      model_reply();
      send_frame();
    end
    @(posedge i_clk);
    while (!(o_rx_ready && exp_q.size() == 0))
      @(posedge i_clk);
    // quiet tail where a late byte trips the monitor
    repeat (32) @(posedge i_clk);
    $display("All checks passed");
    $finish;
  end

endmodule
